// ==== list.f ====
+incdir+.
csr_pkg.sv
csr_exc_regs.sv
csr_timer.sv
csr_save_regs.sv
csr_file.sv
tb_csr_file.sv

// ==== Bender.yml ====
package:
  name: csr_file

sources:
  - csr_pkg.sv
  - csr_exc_regs.sv
  - csr_timer.sv
  - csr_save_regs.sv
  - csr_file.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_csr_file.sv

// ==== tb_csr_ref.svh ====
`ifndef TB_CSR_REF_SVH
`define TB_CSR_REF_SVH

// bits that software can change in each register
function automatic logic [31:0] writable_bits(input logic [13:0] num);
    case (num)
        CSR_CRMD:   return 32'h0000_000f;
        CSR_PRMD:   return 32'h0000_0007;
        CSR_ECFG:   return 32'h0000_1bff;  // bit 10 reserved
        CSR_ESTAT:  return 32'h0000_0003;  // software IS only
        CSR_ERA, CSR_BADV, CSR_TID, CSR_TCFG: return 32'hffff_ffff;
        CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3: return 32'hffff_ffff;
        CSR_EENTRY: return 32'hffff_ffc0;
        default:    return 32'h0;
    endcase
endfunction

function automatic logic [31:0] model_write(input logic [13:0] num, input logic [31:0] old,
                                            input logic [31:0] val, input logic [31:0] mask);
    logic [31:0] wr;
    wr = mask & writable_bits(num);
    return (old & ~wr) | (val & wr);
endfunction

// ESTAT as software sees it
function automatic logic [31:0] estat_layout(input logic [12:0] is, input logic [5:0] ecode,
                                             input logic [8:0] esub);
    return {1'b0, esub, ecode, 3'b0, is};
endfunction

function automatic logic [31:0] timer_step(input logic [31:0] cnt, input logic en,
                                           input logic periodic, input logic [29:0] init);
    if (!en || cnt == 32'hffff_ffff)
        return cnt;  // idle or stopped
    if (cnt == 32'h0 && periodic)
        return {init, 2'b00};
    return cnt - 32'd1;
endfunction

function automatic logic int_pending(input logic [12:0] lie, input logic [12:0] is,
                                     input logic ie);
    return ie && ((lie & is) != 13'h0);
endfunction

`endif

// ==== tb_csr_file.sv ====
`timescale 1ns/10ps
module tb_csr_file;
    import csr_pkg::*;

    localparam int n_rw = 200;
    localparam int n_ex = 30;
    localparam int n_int = 60;
    localparam int max_cycles = 2 * (16 + n_rw * 6 + n_ex * 21 + n_int * 8 + 400);
    localparam int sel_rv = 0, sel_has = 1, sel_exe = 2, sel_ertn = 3;
    localparam int sel_plv = 4, sel_tval = 5, sel_tflag = 6, sel_da = 7;

    logic clk = 0, reset;
    logic [13:0] csr_num;
    logic csr_we, wb_ex, ertn_flush, ipi_int_in, current_exc_fetch;
    logic [31:0] csr_wmask, csr_wvalue, wb_pc, wb_vaddr;
    logic [7:0] hw_int_in;
    logic [5:0] wb_ecode;
    logic [8:0] wb_esubcode;
    logic [31:0] csr_rvalue, ex_entry, ertn_entry;
    logic has_int, csr_direct_addr;
    logic [1:0] csr_crmd_plv;

    logic [31:0] model [0:127];
    logic [31:0] m_cnt, tcfg_w, chk_exp, exp_now, act;
    logic [29:0] m_init;
    logic m_en, m_per, m_flag, chk_pending = 0;
    int chk_sel, n_checks = 0, n_errors = 0, cycle_cnt = 0;
    string chk_name;
    integer seed = 32'hd0ca8cbe;

    `include "tb_csr_ref.svh"

    csr_file u_dut (.*);

    always #10 clk = ~clk;

    // **************************************************
    // timer reference, follows the driven inputs
    // **************************************************
    assign tcfg_w = model_write(CSR_TCFG, {m_init, m_per, m_en}, csr_wvalue, csr_wmask);

    always @(posedge clk) begin
        if (reset) begin
            m_cnt <= '1;
            {m_init, m_per, m_en} <= '0;
            m_flag <= 0;
        end else begin
            if (m_cnt == 0)
                m_flag <= 1;
            else if (csr_we && csr_num == CSR_TICLR && csr_wmask[0] && csr_wvalue[0])
                m_flag <= 0;
            if (csr_we && csr_num == CSR_TCFG) begin
                {m_init, m_per, m_en} <= tcfg_w;
                m_cnt <= tcfg_w[0] ? {tcfg_w[31:2], 2'b00}
                                   : timer_step(m_cnt, m_en, m_per, m_init);
            end else begin
                m_cnt <= timer_step(m_cnt, m_en, m_per, m_init);
            end
        end
    end

    // compare on the falling edge, outputs settled
    always @(negedge clk) begin
        if (chk_pending) begin
            chk_pending = 0;
            exp_now = chk_exp;
            case (chk_sel)
                sel_has:   act = {31'b0, has_int};
                sel_exe:   act = ex_entry;
                sel_ertn:  act = ertn_entry;
                sel_plv:   act = {30'b0, csr_crmd_plv};
                sel_tflag: act = {31'b0, csr_rvalue[timer_int_bit]};
                sel_da:    act = {31'b0, csr_direct_addr};
                default:   act = csr_rvalue;
            endcase
            if (chk_sel == sel_tval)
                exp_now = m_cnt;
            if (chk_sel == sel_tflag)
                exp_now = {31'b0, m_flag};
            n_checks++;
            assert (act === exp_now)
            else begin
                $display("Fail %s: expected %h, actual %h", chk_name, exp_now, act);
                n_errors++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= max_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", max_cycles);
            $display("Verification failed");
            $finish;
        end
    end

    // TCFG enable held low so the counter stays idle
    function automatic logic [31:0] keep_timer_off(input logic [13:0] num,
                                                   input logic [31:0] val);
        return (num == CSR_TCFG) ? (val & ~32'h1) : val;
    endfunction

    task automatic request(input int sel, input logic [31:0] exp, input string name);
        chk_sel = sel;
        chk_exp = exp;
        chk_name = name;
        chk_pending = 1;
    endtask

    task automatic check_reg(input logic [13:0] num, input int sel, input string name);
        @(posedge clk);
        csr_num <= num;
        request(sel, model[num[6:0]], name);
    endtask

    task automatic check_sig(input int sel, input logic [31:0] exp, input string name);
        @(posedge clk);
        request(sel, exp, name);
    endtask

    task automatic do_write(input logic [13:0] num, input logic [31:0] val,
                            input logic [31:0] mask);
        @(posedge clk);
        csr_num <= num;
        csr_we <= 1;
        csr_wvalue <= val;
        csr_wmask <= mask;
        if (num[13:7] == 0)
            model[num[6:0]] = model_write(num, model[num[6:0]], val, mask);
        @(posedge clk);
        csr_we <= 0;
    endtask

    task automatic do_exception(input logic [5:0] ecode, input logic [8:0] esub,
                                input logic [31:0] pc, input logic [31:0] va, input logic fetch);
        @(posedge clk);
        wb_ex <= 1;
        wb_ecode <= ecode;
        wb_esubcode <= esub;
        wb_pc <= pc;
        wb_vaddr <= va;
        current_exc_fetch <= fetch;
        model[CSR_PRMD] = (model[CSR_PRMD] & ~32'h7) | (model[CSR_CRMD] & 32'h7);
        model[CSR_CRMD] = model[CSR_CRMD] & ~32'h7;
        model[CSR_ERA] = pc;
        model[CSR_ESTAT] = estat_layout(model[CSR_ESTAT][12:0], ecode, esub);
        if (ecode == ECODE_ADE || ecode == ECODE_ALE)
            model[CSR_BADV] = fetch ? pc : va;
        @(posedge clk);
        wb_ex <= 0;
    endtask

    task automatic do_ertn;
        @(posedge clk);
        ertn_flush <= 1;
        model[CSR_CRMD] = (model[CSR_CRMD] & ~32'h7) | (model[CSR_PRMD] & 32'h7);
        @(posedge clk);
        ertn_flush <= 0;
    endtask

    task automatic timer_run(input logic [31:0] tcfg, input int cycles, input string name);
        do_write(CSR_TCFG, tcfg, 32'hffff_ffff);
        repeat (cycles)
            check_reg(CSR_TVAL, sel_tval, name);
    endtask

    initial begin
        logic [13:0] kept [13];
        logic [13:0] unmapped [6];
        logic [5:0] ecodes [6];
        logic [13:0] num;
        logic [12:0] is;
        logic [7:0] hw;
        logic ipi;
        kept = '{CSR_CRMD, CSR_PRMD, CSR_ECFG, CSR_ESTAT, CSR_ERA, CSR_BADV, CSR_EENTRY,
                 CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_TID, CSR_TCFG};
        unmapped = '{14'h002, 14'h018, 14'h034, 14'h043, 14'h180, 14'h3fff};
        ecodes = '{ECODE_INT, ECODE_ADE, ECODE_ALE, ECODE_SYS, ECODE_BRK, ECODE_INE};
        reset = 1;
        {csr_num, csr_we, csr_wmask, csr_wvalue, wb_ex, ertn_flush} = '0;
        {ipi_int_in, hw_int_in, wb_pc, wb_ecode, wb_esubcode, wb_vaddr} = '0;
        current_exc_fetch = 0;
        foreach (model[i])
            model[i] = 0;
        model[CSR_CRMD] = 32'h8;  // DA set
        model[CSR_TID] = core_id;
        repeat (8) @(posedge clk);
        reset <= 0;

        // reset values
        check_reg(CSR_CRMD, sel_rv, "reset crmd");
        check_reg(CSR_PRMD, sel_rv, "reset prmd");
        check_reg(CSR_ECFG, sel_rv, "reset ecfg");
        check_reg(CSR_TID, sel_rv, "reset tid");
        check_reg(CSR_TCFG, sel_rv, "reset tcfg");
        check_reg(CSR_TVAL, sel_tval, "reset tval");
        check_sig(sel_has, 0, "reset has_int");
        check_sig(sel_da, 32'h1, "reset da");

        // **************************************************
        // masked write and readback
        // **************************************************
        do_exception(ECODE_SYS, 9'h0, 32'h1c00_0000, 32'h0, 0);
        check_reg(CSR_ESTAT, sel_rv, "reset estat is");
        foreach (kept[i])
            do_write(kept[i], keep_timer_off(kept[i], $random(seed)), 32'hffff_ffff);
        for (int i = 0; i < n_rw; i++) begin
            num = kept[$unsigned($random(seed)) % 13];
            do_write(num, keep_timer_off(num, $random(seed)), $random(seed));
            check_reg(num, sel_rv, "masked write");
            check_sig(sel_da, {31'b0, model[CSR_CRMD][3]}, "crmd da");
            check_reg(kept[$unsigned($random(seed)) % 13], sel_rv, "other register");
            num = unmapped[$unsigned($random(seed)) % 6];
            @(posedge clk);
            csr_num <= num;
            request(sel_rv, 32'h0, "unmapped read");
        end

        // **************************************************
        // exception entry and return
        // **************************************************
        for (int i = 0; i < n_ex; i++) begin
            do_write(CSR_CRMD, $random(seed), 32'h7);
            do_write(CSR_EENTRY, $random(seed), 32'hffff_ffff);
            do_exception(ecodes[$unsigned($random(seed)) % 6], $random(seed), $random(seed),
                         $random(seed), $random(seed));
            check_reg(CSR_CRMD, sel_rv, "entry crmd");
            check_reg(CSR_PRMD, sel_rv, "entry prmd");
            check_reg(CSR_ERA, sel_rv, "entry era");
            check_reg(CSR_ESTAT, sel_rv, "entry estat");
            check_reg(CSR_BADV, sel_rv, "entry badv");
            check_sig(sel_exe, model[CSR_EENTRY], "ex_entry");
            do_write(CSR_PRMD, $random(seed), 32'h7);
            do_ertn();
            check_reg(CSR_CRMD, sel_rv, "return crmd");
            check_sig(sel_plv, model[CSR_CRMD] & 32'h3, "return plv");
            check_sig(sel_ertn, model[CSR_ERA], "ertn_entry");
        end

        // interrupts, timer flag still clear here
        for (int i = 0; i < n_int; i++) begin
            do_write(CSR_ECFG, $random(seed), 32'hffff_ffff);
            do_write(CSR_CRMD, $random(seed), 32'h4);
            do_write(CSR_ESTAT, $random(seed), 32'h3);
            hw = $random(seed);
            ipi = $random(seed);
            @(posedge clk);
            hw_int_in <= hw;
            ipi_int_in <= ipi;
            is = {ipi, 2'b00, hw, model[CSR_ESTAT][1:0]};
            check_sig(sel_has, int_pending(model[CSR_ECFG][12:0], is, model[CSR_CRMD][2]),
                      "has_int");
        end
        @(posedge clk);
        hw_int_in <= 0;
        ipi_int_in <= 0;

        // **************************************************
        // timer, one-shot then periodic
        // **************************************************
        do_write(CSR_ECFG, 32'h800, 32'hffff_ffff);
        do_write(CSR_CRMD, 32'h4, 32'h4);
        timer_run({30'd6, 2'b01}, 30, "one-shot tval");
        check_reg(CSR_ESTAT, sel_tflag, "timer flag set");
        check_sig(sel_has, 1, "timer has_int");
        do_write(CSR_TICLR, 32'h1, 32'h1);
        check_reg(CSR_ESTAT, sel_tflag, "timer flag cleared");
        check_sig(sel_has, 0, "has_int after clear");
        timer_run({30'd3, 2'b11}, 30, "periodic tval");
        do_write(CSR_TCFG, 32'h0, 32'hffff_ffff);
        @(negedge clk);

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// ==== csr_file.sv ====
`timescale 1ns/10ps
module csr_file (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [csr_pkg::csr_num_w-1:0]   csr_num,
    input  logic                            csr_we,
    input  logic [31:0]                     csr_wmask,
    input  logic [31:0]                     csr_wvalue,
    input  logic                            wb_ex,
    input  logic                            ertn_flush,
    input  logic                            ipi_int_in,
    input  logic [csr_pkg::hw_int_w-1:0]    hw_int_in,
    input  logic [31:0]                     wb_pc,
    input  logic [csr_pkg::ecode_w-1:0]     wb_ecode,
    input  logic [csr_pkg::esubcode_w-1:0]  wb_esubcode,
    input  logic [31:0]                     wb_vaddr,
    input  logic                            current_exc_fetch,
    output logic [31:0]                     csr_rvalue,
    output logic                            has_int,
    output logic [31:0]                     ex_entry,
    output logic [31:0]                     ertn_entry,
    output logic [1:0]                      csr_crmd_plv,
    output logic                            csr_direct_addr
);

    logic [31:0] exc_rdata;
    logic [31:0] timer_rdata;
    logic [31:0] save_rdata;
    logic        timer_int;

    // **************************************************
    // register banks
    // **************************************************
    csr_exc_regs u_exc_regs (
        .clk               (clk),
        .reset             (reset),
        .csr_num           (csr_num),
        .csr_we            (csr_we),
        .csr_wmask         (csr_wmask),
        .csr_wvalue        (csr_wvalue),
        .wb_ex             (wb_ex),
        .ertn_flush        (ertn_flush),
        .wb_ecode          (wb_ecode),
        .wb_esubcode       (wb_esubcode),
        .wb_pc             (wb_pc),
        .wb_vaddr          (wb_vaddr),
        .current_exc_fetch (current_exc_fetch),
        .hw_int_in         (hw_int_in),
        .ipi_int_in        (ipi_int_in),
        .timer_int         (timer_int),
        .rdata             (exc_rdata),
        .has_int           (has_int),
        .ex_entry          (ex_entry),
        .ertn_entry        (ertn_entry),
        .crmd_plv          (csr_crmd_plv),
        .crmd_da           (csr_direct_addr)
    );

    csr_timer u_timer (
        .clk        (clk),
        .reset      (reset),
        .csr_num    (csr_num),
        .csr_we     (csr_we),
        .csr_wmask  (csr_wmask),
        .csr_wvalue (csr_wvalue),
        .rdata      (timer_rdata),
        .timer_int  (timer_int)
    );

    csr_save_regs u_save_regs (
        .clk        (clk),
        .csr_num    (csr_num),
        .csr_we     (csr_we),
        .csr_wmask  (csr_wmask),
        .csr_wvalue (csr_wvalue),
        .rdata      (save_rdata)
    );

    // each bank returns zero for numbers it does not own
    assign csr_rvalue = exc_rdata | timer_rdata | save_rdata;

endmodule

// ==== csr_save_regs.sv ====
`timescale 1ns/10ps
module csr_save_regs (
    input  logic                            clk,
    input  logic [csr_pkg::csr_num_w-1:0]   csr_num,
    input  logic                            csr_we,
    input  logic [31:0]                     csr_wmask,
    input  logic [31:0]                     csr_wvalue,
    output logic [31:0]                     rdata
);
    import csr_pkg::*;

    localparam logic [csr_num_w-1:0] save_base = CSR_SAVE0;

    logic [31:0] save_q [4];
    logic        hit;
    logic [1:0]  idx;

    // SAVE0..SAVE3 sit on one aligned group of four
    assign hit = csr_num[csr_num_w-1:2] == save_base[csr_num_w-1:2];
    assign idx = csr_num[1:0];

    always_ff @(posedge clk) begin
        if (csr_we && hit)
            save_q[idx] <= masked_update(save_q[idx], csr_wvalue, csr_wmask);
    end

    assign rdata = hit ? save_q[idx] : 32'b0;

endmodule

// ==== csr_timer.sv ====
`timescale 1ns/10ps
module csr_timer (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [csr_pkg::csr_num_w-1:0]   csr_num,
    input  logic                            csr_we,
    input  logic [31:0]                     csr_wmask,
    input  logic [31:0]                     csr_wvalue,
    output logic [31:0]                     rdata,
    output logic                            timer_int
);
    import csr_pkg::*;

    logic [31:0]                tid_q;
    logic                       en_q;
    logic                       periodic_q;
    logic [31-tcfg_initval_lo:0] initval_q;
    logic [31:0]                cnt_q;
    logic                       flag_q;

    logic [31:0]                tcfg_rd;
    logic [31:0]                tcfg_new;
    logic [31:0]                tid_new;
    logic                       wr_tcfg;
    logic                       ticlr_hit;

    always_comb begin
        tcfg_rd = '0;
        tcfg_rd[tcfg_en_bit] = en_q;
        tcfg_rd[tcfg_periodic_bit] = periodic_q;
        tcfg_rd[31:tcfg_initval_lo] = initval_q;
    end

    assign tcfg_new = masked_update(tcfg_rd, csr_wvalue, csr_wmask);
    assign tid_new  = masked_update(tid_q, csr_wvalue, csr_wmask);
    assign wr_tcfg  = csr_we && csr_num == CSR_TCFG;

    // clear needs bit 0 both written and set
    assign ticlr_hit = csr_we && csr_num == CSR_TICLR
                       && csr_wmask[ticlr_clr_bit] && csr_wvalue[ticlr_clr_bit];

    always_ff @(posedge clk) begin
        if (reset)
            tid_q <= core_id;
        else if (csr_we && csr_num == CSR_TID)
            tid_q <= tid_new;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            en_q       <= 1'b0;
            periodic_q <= 1'b0;
            initval_q  <= '0;
        end else if (wr_tcfg) begin
            en_q       <= tcfg_new[tcfg_en_bit];
            periodic_q <= tcfg_new[tcfg_periodic_bit];
            initval_q  <= tcfg_new[31:tcfg_initval_lo];
        end
    end

    // **************************************************
    // countdown
    // **************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt_q <= '1;
        end else if (wr_tcfg && tcfg_new[tcfg_en_bit]) begin
            cnt_q <= {tcfg_new[31:tcfg_initval_lo], 2'b0};
        end else if (en_q && cnt_q != '1) begin
            if (cnt_q == '0 && periodic_q)
                cnt_q <= {initval_q, 2'b0};  // reload
            else
                cnt_q <= cnt_q - 32'd1;      // one-shot falls to all-ones
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            flag_q <= 1'b0;
        else if (cnt_q == '0)
            flag_q <= 1'b1;  // set beats clear
        else if (ticlr_hit)
            flag_q <= 1'b0;
    end

    assign timer_int = flag_q;

    always_comb begin
        case (csr_num)
            CSR_TID:   rdata = tid_q;
            CSR_TCFG:  rdata = tcfg_rd;
            CSR_TVAL:  rdata = cnt_q;
            default:   rdata = 32'b0;  // TICLR reads zero too
        endcase
    end

endmodule

// ==== csr_exc_regs.sv ====
`timescale 1ns/10ps
module csr_exc_regs (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [csr_pkg::csr_num_w-1:0]   csr_num,
    input  logic                            csr_we,
    input  logic [31:0]                     csr_wmask,
    input  logic [31:0]                     csr_wvalue,
    input  logic                            wb_ex,
    input  logic                            ertn_flush,
    input  logic [csr_pkg::ecode_w-1:0]     wb_ecode,
    input  logic [csr_pkg::esubcode_w-1:0]  wb_esubcode,
    input  logic [31:0]                     wb_pc,
    input  logic [31:0]                     wb_vaddr,
    input  logic                            current_exc_fetch,
    input  logic [csr_pkg::hw_int_w-1:0]    hw_int_in,
    input  logic                            ipi_int_in,
    input  logic                            timer_int,
    output logic [31:0]                     rdata,
    output logic                            has_int,
    output logic [31:0]                     ex_entry,
    output logic [31:0]                     ertn_entry,
    output logic [1:0]                      crmd_plv,
    output logic                            crmd_da
);
    import csr_pkg::*;

    logic [1:0]                 plv_q;
    logic                       ie_q;
    logic                       da_q;
    logic [1:0]                 pplv_q;
    logic                       pie_q;
    logic [int_w-1:0]           lie_q;
    logic [1:0]                 sw_is_q;
    logic [hw_int_w-1:0]        hw_is_q;
    logic                       ipi_is_q;
    logic [ecode_w-1:0]         ecode_q;
    logic [esubcode_w-1:0]      esubcode_q;
    logic [31:0]                era_q;
    logic [31:0]                badv_q;
    logic [31-eentry_va_lo:0]   eentry_va_q;

    logic [int_w-1:0]           estat_is;
    logic [31:0]                crmd_rd, prmd_rd, ecfg_rd, estat_rd, eentry_rd;
    logic [31:0]                crmd_new, prmd_new, ecfg_new, estat_new;
    logic [31:0]                era_new, badv_new, eentry_new;
    logic                       addr_err;

    // **************************************************
    // read layouts, reserved bits zero
    // **************************************************
    always_comb begin
        estat_is = '0;
        estat_is[1:0] = sw_is_q;
        estat_is[hw_int_w+1:2] = hw_is_q;
        estat_is[timer_int_bit] = timer_int;
        estat_is[ipi_int_bit] = ipi_is_q;

        crmd_rd = '0;
        crmd_rd[crmd_plv_lo +: 2] = plv_q;
        crmd_rd[crmd_ie_bit] = ie_q;
        crmd_rd[crmd_da_bit] = da_q;

        prmd_rd = '0;
        prmd_rd[prmd_pplv_lo +: 2] = pplv_q;
        prmd_rd[prmd_pie_bit] = pie_q;

        ecfg_rd = '0;
        ecfg_rd[int_w-1:0] = lie_q;

        estat_rd = '0;
        estat_rd[int_w-1:0] = estat_is;
        estat_rd[estat_ecode_lo +: ecode_w] = ecode_q;
        estat_rd[estat_esubcode_lo +: esubcode_w] = esubcode_q;

        eentry_rd = '0;
        eentry_rd[31:eentry_va_lo] = eentry_va_q;
    end

    assign crmd_new   = masked_update(crmd_rd, csr_wvalue, csr_wmask);
    assign prmd_new   = masked_update(prmd_rd, csr_wvalue, csr_wmask);
    assign ecfg_new   = masked_update(ecfg_rd, csr_wvalue, csr_wmask);
    assign estat_new  = masked_update(estat_rd, csr_wvalue, csr_wmask);
    assign era_new    = masked_update(era_q, csr_wvalue, csr_wmask);
    assign badv_new   = masked_update(badv_q, csr_wvalue, csr_wmask);
    assign eentry_new = masked_update(eentry_rd, csr_wvalue, csr_wmask);

    assign addr_err = (wb_ecode == ECODE_ADE) || (wb_ecode == ECODE_ALE);

    // **************************************************
    // CRMD / PRMD
    // **************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            plv_q <= 2'b0;
            ie_q  <= 1'b0;
            da_q  <= 1'b1;
        end else begin
            if (wb_ex) begin
                plv_q <= 2'b0;
                ie_q  <= 1'b0;
            end else if (ertn_flush) begin
                plv_q <= pplv_q;  // back to the interrupted level
                ie_q  <= pie_q;
            end else if (csr_we && csr_num == CSR_CRMD) begin
                plv_q <= crmd_new[crmd_plv_lo +: 2];
                ie_q  <= crmd_new[crmd_ie_bit];
            end
            if (csr_we && csr_num == CSR_CRMD)
                da_q <= crmd_new[crmd_da_bit];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pplv_q <= 2'b0;
            pie_q  <= 1'b0;
        end else if (wb_ex) begin
            pplv_q <= plv_q;
            pie_q  <= ie_q;
        end else if (csr_we && csr_num == CSR_PRMD) begin
            pplv_q <= prmd_new[prmd_pplv_lo +: 2];
            pie_q  <= prmd_new[prmd_pie_bit];
        end
    end

    // ECFG and the IS bits
    always_ff @(posedge clk) begin
        if (reset) begin
            lie_q    <= '0;
            sw_is_q  <= 2'b0;
            hw_is_q  <= '0;
            ipi_is_q <= 1'b0;
        end else begin
            if (csr_we && csr_num == CSR_ECFG)
                lie_q <= ecfg_new[int_w-1:0] & ecfg_lie_mask;
            if (csr_we && csr_num == CSR_ESTAT)
                sw_is_q <= estat_new[1:0];  // only software bits writable
            hw_is_q  <= hw_int_in;
            ipi_is_q <= ipi_int_in;
        end
    end

    // **************************************************
    // exception capture
    // **************************************************
    always_ff @(posedge clk) begin
        if (wb_ex) begin
            ecode_q    <= wb_ecode;
            esubcode_q <= wb_esubcode;
            era_q      <= wb_pc;
        end else if (csr_we && csr_num == CSR_ERA) begin
            era_q <= era_new;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_ex) begin
            if (addr_err)
                badv_q <= current_exc_fetch ? wb_pc : wb_vaddr;
        end else if (csr_we && csr_num == CSR_BADV) begin
            badv_q <= badv_new;
        end
    end

    always_ff @(posedge clk) begin
        if (csr_we && csr_num == CSR_EENTRY)
            eentry_va_q <= eentry_new[31:eentry_va_lo];
    end

    assign has_int    = (|(estat_is & lie_q)) && ie_q;
    assign ex_entry   = eentry_rd;
    assign ertn_entry = era_q;
    assign crmd_plv   = plv_q;
    assign crmd_da    = da_q;

    always_comb begin
        case (csr_num)
            CSR_CRMD:   rdata = crmd_rd;
            CSR_PRMD:   rdata = prmd_rd;
            CSR_ECFG:   rdata = ecfg_rd;
            CSR_ESTAT:  rdata = estat_rd;
            CSR_ERA:    rdata = era_q;
            CSR_BADV:   rdata = badv_q;
            CSR_EENTRY: rdata = eentry_rd;
            default:    rdata = 32'b0;  // not ours
        endcase
    end

endmodule

// ==== csr_pkg.sv ====
package csr_pkg;

    // widths
    localparam int csr_num_w  = 14;
    localparam int ecode_w    = 6;
    localparam int esubcode_w = 9;
    localparam int int_w      = 13;
    localparam int hw_int_w   = 8;

    typedef enum logic [csr_num_w-1:0] {
        CSR_CRMD   = 14'h000,
        CSR_PRMD   = 14'h001,
        CSR_ECFG   = 14'h004,
        CSR_ESTAT  = 14'h005,
        CSR_ERA    = 14'h006,
        CSR_BADV   = 14'h007,
        CSR_EENTRY = 14'h00c,
        CSR_SAVE0  = 14'h030,
        CSR_SAVE1  = 14'h031,
        CSR_SAVE2  = 14'h032,
        CSR_SAVE3  = 14'h033,
        CSR_TID    = 14'h040,
        CSR_TCFG   = 14'h041,
        CSR_TVAL   = 14'h042,
        CSR_TICLR  = 14'h044
    } csr_num_e;

    typedef enum logic [ecode_w-1:0] {
        ECODE_INT = 6'h00,
        ECODE_ADE = 6'h08,
        ECODE_ALE = 6'h09,
        ECODE_SYS = 6'h0b,
        ECODE_BRK = 6'h0c,
        ECODE_INE = 6'h0d
    } ecode_e;

    // bit 10 of LIE is reserved
    localparam logic [int_w-1:0] ecfg_lie_mask = 13'h1bff;

    localparam int timer_int_bit = 11;
    localparam int ipi_int_bit   = 12;

    localparam logic [31:0] core_id = 32'h0;

    // **************************************************
    // field positions
    // **************************************************
    localparam int crmd_plv_lo = 0;   // 2 bits
    localparam int crmd_ie_bit = 2;
    localparam int crmd_da_bit = 3;

    localparam int prmd_pplv_lo = 0;  // 2 bits
    localparam int prmd_pie_bit = 2;

    localparam int estat_ecode_lo    = 16;
    localparam int estat_esubcode_lo = 22;

    localparam int tcfg_en_bit       = 0;
    localparam int tcfg_periodic_bit = 1;
    localparam int tcfg_initval_lo   = 2;

    localparam int ticlr_clr_bit = 0;

    localparam int eentry_va_lo = 6;

    // new bits under mask, old bits elsewhere
    function automatic logic [31:0] masked_update(
        input logic [31:0] old_val,
        input logic [31:0] new_val,
        input logic [31:0] mask
    );
        return (new_val & mask) | (old_val & ~mask);
    endfunction

endpackage
